// File: list.f
+incdir+source
+incdir+tests
source/icecap_pkg.sv
source/capture_ram.sv
source/sump_cmd_decoder.sv
source/capture_engine.sv
source/id_reporter.sv
source/tx_sequencer.sv
source/icecap_top.sv
tests/tb_icecap.sv

// File: source/capture_engine.sv
// cfg must stay stable from arm until readback ends
// readback always returns the full memory, oldest sample first
// trigger compares levels only, edges are not detected
`timescale 1ns/1ps
`include "icecap_macros.svh"
module capture_engine (
	input  logic                  CAP_CLK,
	input  logic                  rst_n,
	input  logic [7:0]            cap,
	input  icecap_pkg::cap_cfg_t  cfg,
	input  logic                  arm,
	output icecap_pkg::byte_req_t out_req,
	input  logic                  out_taken,
	output logic                  active
);
	typedef enum logic [1:0] {ST_IDLE, ST_CAPT, ST_LOAD, ST_SHOW} eng_state_e;

	eng_state_e         state;
	logic [8:0]         tick;        // sample pacing
	logic [`CAP_AW-1:0] waddr;
	logic [`CAP_AW-1:0] raddr;
	logic [`CAP_AW-1:0] rd_cnt;      // bytes already sent
	logic [`CAP_AW-1:0] stop_addr;   // fixed at trigger
	logic [`CAP_AW-1:0] cur_stop;
	logic               trig_fired;
	logic               samp;
	logic               hit;
	logic               mask_on;
	logic               last_wr;
	logic [7:0]         rdata;

	assign samp     = (state == ST_CAPT) && (tick == 9'd0);
	assign mask_on  = |cfg.trig_mask;
	assign hit      = ((cap ^ cfg.trig_sens) & cfg.trig_mask) == 8'h00;
	// before the trigger the stop would follow from the current address
	assign cur_stop = trig_fired ? stop_addr : waddr + cfg.post_count[`CAP_AW-1:0];
	assign last_wr  = mask_on ? ((trig_fired | hit) && (waddr == cur_stop)) : &waddr;

	assign out_req  = '{ready: (state == ST_SHOW), data: rdata};
	assign active   = (state != ST_IDLE);

	capture_ram u_ram (
		.CAP_CLK (CAP_CLK),
		.we      (samp),
		.waddr   (waddr),
		.wdata   (cap),              // value at the write edge is the sample
		.re      (state == ST_LOAD),
		.raddr   (raddr),
		.rdata   (rdata)
	);

	always_ff @(posedge CAP_CLK or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			tick       <= 9'd0;
			waddr      <= '0;
			raddr      <= '0;
			rd_cnt     <= '0;
			stop_addr  <= '0;
			trig_fired <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (arm) begin
					state      <= ST_CAPT;
					tick       <= 9'd0;     // first sample next edge
					waddr      <= '0;
					trig_fired <= 1'b0;
				end
				ST_CAPT: begin
					tick <= (tick == cfg.tick_limit) ? 9'd0 : tick + 9'd1;
					if (samp) begin
						waddr <= waddr + 1'b1;   // wraps at depth
						if (mask_on && !trig_fired && hit) begin
							trig_fired <= 1'b1;
							stop_addr  <= cur_stop;
						end
						if (last_wr) begin
							state  <= ST_LOAD;
							raddr  <= waddr + 1'b1;   // oldest sample
							rd_cnt <= '0;
						end
					end
				end
				ST_LOAD: state <= ST_SHOW;        // one read in flight
				ST_SHOW: if (out_taken) begin
					if (&rd_cnt) begin
						state <= ST_IDLE;           // last byte gone
					end else begin
						state  <= ST_LOAD;
						raddr  <= raddr + 1'b1;
						rd_cnt <= rd_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end
endmodule

// File: source/capture_ram.sv
// read data appears one clock after re and holds until the next read
// contents start at zero and are kept across captures
`timescale 1ns/1ps
`include "icecap_macros.svh"
module capture_ram (
	input  logic              CAP_CLK,
	input  logic              we,
	input  logic [`CAP_AW-1:0] waddr,
	input  logic [7:0]        wdata,
	input  logic              re,
	input  logic [`CAP_AW-1:0] raddr,
	output logic [7:0]        rdata
);
	logic [7:0] mem [0:`CAP_DEPTH-1];

	initial begin
		for (int i = 0; i < `CAP_DEPTH; i++)
			mem[i] = 8'h00;      // memory starts blank
	end

	always @(posedge CAP_CLK) begin
		if (we)
			mem[waddr] <= wdata;
		if (re)
			rdata <= mem[raddr];   // registered read port
	end
endmodule

// File: source/icecap_macros.svh
// divider codes follow the SUMP 100 MHz reference convention
// tick limits assume CAP_CLK runs at 48 MHz
// CAP_AW sets the memory depth, keep it at 16 or below
`ifndef ICECAP_MACROS_SVH
`define ICECAP_MACROS_SVH

`define CAP_AW    8                 // sample address width
`define CAP_DEPTH (1 << `CAP_AW)    // bytes of sample memory

// divider codes as sent with 0x80
`define DIV_C0 24'd1     // 48 MHz
`define DIV_C1 24'd3     // 24 MHz
`define DIV_C2 24'd7     // 12 MHz
`define DIV_C3 24'd15    // 6 MHz
`define DIV_C4 24'd24    // 4 MHz
`define DIV_C5 24'd49    // 2 MHz
`define DIV_C6 24'd99    // 1 MHz
`define DIV_C7 24'd199   // 500 kHz
`define DIV_C8 24'd499   // 200 kHz
`define DIV_C9 24'd999   // 100 kHz

// last tick value per code, sample taken every limit+1 clocks
`define TICK_L0 9'd0
`define TICK_L1 9'd1
`define TICK_L2 9'd3
`define TICK_L3 9'd7
`define TICK_L4 9'd11
`define TICK_L5 9'd23
`define TICK_L6 9'd47
`define TICK_L7 9'd95
`define TICK_L8 9'd239
`define TICK_L9 9'd479

// ID answer "1ALS"
`define ID_B0 8'h31
`define ID_B1 8'h41
`define ID_B2 8'h4C
`define ID_B3 8'h53

`endif

// File: source/icecap_pkg.sv
// types shared by the SUMP capture core
// post_count is already scaled to samples
package icecap_pkg;

	// SUMP opcodes handled or skipped by the decoder
	typedef enum logic [7:0] {
		CMD_RESET     = 8'h00,
		CMD_ARM       = 8'h01,
		CMD_ID        = 8'h02,
		CMD_META      = 8'h04,   // not supported, skipped
		CMD_DIV       = 8'h80,
		CMD_COUNT     = 8'h81,
		CMD_FLAGS     = 8'h82,   // consumed and dropped
		CMD_TRIG_MASK = 8'hC0,
		CMD_TRIG_VAL  = 8'hC1,
		CMD_TRIG_CONF = 8'hC2    // consumed and dropped
	} sump_cmd_e;

	// capture setup held by the decoder
	typedef struct packed {
		logic [7:0]  trig_mask;    // channels taking part in trigger
		logic [7:0]  trig_sens;    // level wanted on masked channels
		logic [15:0] post_count;   // samples kept after trigger
		logic [8:0]  tick_limit;   // from divider table
		logic        rate_ok;      // divider code was in table
	} cap_cfg_t;

	// byte offered to the transmit side
	typedef struct packed {
		logic       ready;
		logic [7:0] data;
	} byte_req_t;

endpackage

// File: source/icecap_top.sv
// byte link in and out, UART bit engines sit outside this core
// busy covers capture, readback and the ID report
`timescale 1ns/1ps
module icecap_top (
	input  logic       CAP_CLK,
	input  logic       rst_n,
	input  logic [7:0] cap,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	input  logic       tx_busy,
	output logic       tx_start,
	output logic [7:0] tx_data,
	output logic       busy
);
	import icecap_pkg::*;

	cap_cfg_t  cfg;
	logic      arm;
	logic      id_req;
	byte_req_t cap_req;
	byte_req_t id_byte;
	logic      cap_taken;
	logic      id_taken;
	logic      cap_active;
	logic      id_active;

	assign busy = cap_active | id_active;   // fed back to hold off commands

	sump_cmd_decoder u_decoder (
		.CAP_CLK  (CAP_CLK),
		.rst_n    (rst_n),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.busy     (busy),
		.cfg      (cfg),
		.arm      (arm),
		.id_req   (id_req)
	);

	capture_engine u_engine (
		.CAP_CLK   (CAP_CLK),
		.rst_n     (rst_n),
		.cap       (cap),
		.cfg       (cfg),
		.arm       (arm),
		.out_req   (cap_req),
		.out_taken (cap_taken),
		.active    (cap_active)
	);

	id_reporter u_id (
		.CAP_CLK   (CAP_CLK),
		.rst_n     (rst_n),
		.id_req    (id_req),
		.out_req   (id_byte),
		.out_taken (id_taken),
		.active    (id_active)
	);

	tx_sequencer u_tx (
		.CAP_CLK     (CAP_CLK),
		.rst_n       (rst_n),
		.cap_req     (cap_req),
		.id_req_byte (id_byte),
		.cap_taken   (cap_taken),
		.id_taken    (id_taken),
		.tx_busy     (tx_busy),
		.tx_start    (tx_start),
		.tx_data     (tx_data)
	);
endmodule

// File: source/id_reporter.sv
// an id_req during a running report restarts it from the first byte
`timescale 1ns/1ps
`include "icecap_macros.svh"
module id_reporter (
	input  logic                  CAP_CLK,
	input  logic                  rst_n,
	input  logic                  id_req,
	output icecap_pkg::byte_req_t out_req,
	input  logic                  out_taken,
	output logic                  active
);
	logic [1:0] idx;       // byte being offered
	logic [7:0] id_byte;

	always_comb begin
		case (idx)
			2'd0:    id_byte = `ID_B0;
			2'd1:    id_byte = `ID_B1;
			2'd2:    id_byte = `ID_B2;
			default: id_byte = `ID_B3;
		endcase
	end

	assign out_req = '{ready: active, data: id_byte};

	always_ff @(posedge CAP_CLK or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			idx    <= 2'd0;
		end else if (id_req) begin
			active <= 1'b1;
			idx    <= 2'd0;
		end else if (active && out_taken) begin
			idx <= idx + 2'd1;
			if (idx == 2'd3)
				active <= 1'b0;      // "S" sent, done
		end
	end
endmodule

// File: source/sump_cmd_decoder.sv
// every byte including parameters is dropped while busy is high
// a divider code outside the table clears rate_ok and arm is then ignored
// new setup is visible one clock after the last parameter byte
`timescale 1ns/1ps
`include "icecap_macros.svh"
module sump_cmd_decoder (
	input  logic                 CAP_CLK,
	input  logic                 rst_n,
	input  logic                 rx_valid,
	input  logic [7:0]           rx_data,
	input  logic                 busy,
	output icecap_pkg::cap_cfg_t cfg,
	output logic                 arm,
	output logic                 id_req
);
	import icecap_pkg::*;

	sump_cmd_e   cmd;          // long command being collected
	logic        collecting;   // parameter bytes still due
	logic [1:0]  pidx;         // index of next parameter
	logic [7:0]  prm [0:2];    // params 0..2 while param 3 is used from rx_data
	logic        take;
	logic [23:0] div_code;
	logic [8:0]  div_lim;
	logic        div_ok;

	assign take     = rx_valid & ~busy;
	assign div_code = {prm[2], prm[1], prm[0]};   // 24-bit divider sent LSB first

	// divider table lookup
	always_comb begin
		div_ok = 1'b1;
		case (div_code)
			`DIV_C0: div_lim = `TICK_L0;
			`DIV_C1: div_lim = `TICK_L1;
			`DIV_C2: div_lim = `TICK_L2;
			`DIV_C3: div_lim = `TICK_L3;
			`DIV_C4: div_lim = `TICK_L4;
			`DIV_C5: div_lim = `TICK_L5;
			`DIV_C6: div_lim = `TICK_L6;
			`DIV_C7: div_lim = `TICK_L7;
			`DIV_C8: div_lim = `TICK_L8;
			`DIV_C9: div_lim = `TICK_L9;
			default: begin
				div_lim = 9'd0;
				div_ok  = 1'b0;    // unknown rate
			end
		endcase
	end

	always_ff @(posedge CAP_CLK or negedge rst_n) begin
		if (!rst_n) begin
			cmd        <= CMD_RESET;
			collecting <= 1'b0;
			pidx       <= 2'd0;
			cfg        <= '0;
			arm        <= 1'b0;
			id_req     <= 1'b0;
		end else begin
			arm    <= 1'b0;              // single cycle pulses
			id_req <= 1'b0;
			if (take && collecting) begin
				pidx <= pidx + 2'd1;
				if (pidx == 2'd3) begin   // fourth parameter applies the command
					collecting <= 1'b0;
					case (cmd)
						CMD_TRIG_MASK: cfg.trig_mask  <= prm[0];
						CMD_TRIG_VAL:  cfg.trig_sens  <= prm[0];
						CMD_COUNT:     cfg.post_count <= {rx_data[5:0], prm[2], 2'b00};
						CMD_DIV: begin
							cfg.tick_limit <= div_lim;
							cfg.rate_ok    <= div_ok;
						end
						default: ;               // 0xC2 and 0x82 dropped here
					endcase
				end
			end else if (take) begin
				case (rx_data)
					CMD_TRIG_MASK, CMD_TRIG_VAL, CMD_TRIG_CONF,
					CMD_COUNT, CMD_DIV, CMD_FLAGS: begin
						cmd        <= sump_cmd_e'(rx_data);
						collecting <= 1'b1;
						pidx       <= 2'd0;
					end
					CMD_ARM: arm    <= cfg.rate_ok;
					CMD_ID:  id_req <= 1'b1;
					CMD_RESET, CMD_META: ;      // accepted without action
					default: ;
				endcase
			end
		end
	end

	// parameter byte store
	always_ff @(posedge CAP_CLK) begin
		if (take && collecting && pidx != 2'd3) begin
			prm[pidx] <= rx_data;
		end
	end
endmodule

// File: source/tx_sequencer.sv
// capture bytes win over ID bytes, the two never run together
// tx_start is combinational from source ready and tx_busy
// the line driver must raise tx_busy within one clock of tx_start
`timescale 1ns/1ps
module tx_sequencer (
	input  logic                  CAP_CLK,
	input  logic                  rst_n,
	input  icecap_pkg::byte_req_t cap_req,
	input  icecap_pkg::byte_req_t id_req_byte,
	output logic                  cap_taken,
	output logic                  id_taken,
	input  logic                  tx_busy,
	output logic                  tx_start,
	output logic [7:0]            tx_data
);
	logic hold;        // clock right after a start, busy may lag
	logic any_ready;

	assign any_ready = cap_req.ready | id_req_byte.ready;

	// start only from a free line and never during hold
	assign tx_start  = any_ready & ~hold & ~tx_busy;
	assign tx_data   = cap_req.ready ? cap_req.data : id_req_byte.data;

	// taken goes back to whichever source was sent
	assign cap_taken = tx_start & cap_req.ready;
	assign id_taken  = tx_start & ~cap_req.ready;

	// after hold the ~tx_busy term does the waiting
	always_ff @(posedge CAP_CLK or negedge rst_n) begin
		if (!rst_n) begin
			hold <= 1'b0;
		end else begin
			hold <= tx_start;
		end
	end
endmodule

// File: tests/tb_icecap_model.svh
// reference helpers, included inside tb_icecap and using its hist array
// ref_mem mirrors the sample memory and keeps its contents between captures
// hist holds cap by edge number, the model picks samples from it by the timing rule

logic [7:0] ref_mem [0:`CAP_DEPTH-1];
logic [7:0] exp_q [$];          // expected readback, oldest first

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

task automatic clear_ref_mem();
	int i;
	for (i = 0; i < `CAP_DEPTH; i++)
		ref_mem[i] = 8'h00;     // sample memory starts blank
endtask

// replays one capture from the arm edge e, then lists the circular readback
task automatic build_expected(input int e, input int lim, input logic [7:0] mask,
		input logic [7:0] sens, input logic [15:0] post, output bit found);
	int         k;
	int         edge_i;
	int         addr;
	int         stop;
	int         i;
	bit         fired;
	logic [7:0] s;
	k      = 0;
	stop   = 0;
	fired  = 1'b0;
	found  = 1'b0;
	exp_q.delete();
	while (!found && k < 65536) begin
		edge_i = e + 2 + k * (lim + 1);     // sample k edge
		if (edge_i >= HIST_N)
			break;
		s            = hist[edge_i];
		addr         = k % `CAP_DEPTH;
		ref_mem[addr] = s;
		if (mask == 8'h00) begin
			found = (addr == `CAP_DEPTH - 1);   // one pass, no trigger
			stop  = addr;
		end else begin
			if (!fired && ((s ^ sens) & mask) == 8'h00) begin
				fired = 1'b1;
				stop  = (addr + post) % `CAP_DEPTH;
			end
			found = fired && (addr == stop);
		end
		k++;
	end
	for (i = 0; i < `CAP_DEPTH; i++)
		exp_q.push_back(ref_mem[(stop + 1 + i) % `CAP_DEPTH]);
endtask

// File: tests/tb_icecap.sv
// inputs change 1 ns after the rising edge, DUT outputs are read at the falling edge
// tx_busy model answers each tx_start with 3 to 10 busy cycles
// stops at the first failed check
`timescale 1ns/1ps
`include "icecap_macros.svh"
module tb_icecap;
	localparam int HIST_N = 1 << 16;

	logic        CAP_CLK = 1'b0;
	logic        rst_n;
	logic [7:0]  cap;
	logic        rx_valid;
	logic [7:0]  rx_data;
	logic        tx_busy;
	logic        tx_start;
	logic [7:0]  tx_data;
	logic        busy;

	int          cyc;               // rising edges so far, also next edge index
	int          last_edge;         // edge that saw the last command byte
	int          busy_left;
	logic [31:0] rng;
	logic        start_seen;
	logic [7:0]  hist [0:HIST_N-1]; // cap by edge index
	logic [7:0]  got [$];           // bytes sent by the DUT
	logic [7:0]  m_mask;            // expected decoder setup
	logic [7:0]  m_sens;
	logic [15:0] m_post;
	int          m_lim;

	`include "tb_icecap_model.svh"

	icecap_top u_icecap_top (
		.CAP_CLK  (CAP_CLK),
		.rst_n    (rst_n),
		.cap      (cap),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.busy     (busy)
	);

	always #4 CAP_CLK = ~CAP_CLK;   // 8 ns period

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_error(input string msg);
		stop_run($sformatf("** Error @ %0t ns: %s", $time, msg));
	endtask

	// random samples and line driver busy, one draw per edge
	always @(posedge CAP_CLK) begin
		cyc = cyc + 1;
		#1;
		rng = xorshift(rng);
		cap = rng[7:0];
		if (start_seen) begin
			tx_busy   = 1'b1;                    // edge after tx_start
			busy_left = 3 + int'(rng[18:16]);
		end else if (busy_left > 0) begin
			busy_left = busy_left - 1;
			if (busy_left == 0)
				tx_busy = 1'b0;
		end
	end

	always @(negedge CAP_CLK) begin
		if (cyc < HIST_N)
			hist[cyc] = cap;          // value the next edge will see
		start_seen = tx_start;
		if (tx_start) begin
			assert (tx_busy == 1'b0) else value_error("tx_start issued while tx_busy high");
			got.push_back(tx_data);
		end
	end

	task automatic send_byte(input logic [7:0] b);
		@(posedge CAP_CLK);
		#1;
		rx_valid  = 1'b1;
		rx_data   = b;
		last_edge = cyc;
		@(posedge CAP_CLK);
		#1;
		rx_valid = 1'b0;
	endtask

	task automatic send_cmd5(input logic [7:0] op, input logic [7:0] p0,
			input logic [7:0] p1, input logic [7:0] p2, input logic [7:0] p3);
		send_byte(op);
		send_byte(p0);
		send_byte(p1);
		send_byte(p2);
		send_byte(p3);
	endtask

	task automatic set_divider(input logic [23:0] code, input int lim);
		send_cmd5(8'h80, code[7:0], code[15:8], code[23:16], 8'h00);
		m_lim = lim;
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(posedge CAP_CLK);
			#1;
			n++;
		end
		assert (busy === level) else stop_run({"timeout while waiting: ", what});
	endtask

	// arm, wait for the readback and compare it with the model
	task automatic run_capture(input string name);
		int e;
		int i;
		bit found;
		got.delete();
		send_byte(8'h01);
		e = last_edge;
		wait_busy(1'b1, 20, {name, " capture start"});
		wait_busy(1'b0, 200000, {name, " readback end"});
		build_expected(e, m_lim, m_mask, m_sens, m_post, found);
		assert (found) else stop_run({name, ": model found no stop address"});
		assert (got.size() == `CAP_DEPTH)
			else value_error($sformatf("%s: %0d bytes, expected %0d", name, got.size(), `CAP_DEPTH));
		for (i = 0; i < `CAP_DEPTH; i++)
			assert (got[i] == exp_q[i])
				else value_error($sformatf("%s: byte %0d is %02h, expected %02h",
					name, i, got[i], exp_q[i]));
	endtask

	initial begin
		rst_n      = 1'b0;
		cap        = 8'h00;
		rx_valid   = 1'b0;
		rx_data    = 8'h00;
		tx_busy    = 1'b0;
		cyc        = 0;
		last_edge  = 0;
		busy_left  = 0;
		start_seen = 1'b0;
		rng        = 32'h18c15929;
		m_mask     = 8'h00;        // decoder setup is zero after reset
		m_sens     = 8'h00;
		m_post     = 16'h0000;
		m_lim      = 0;
		clear_ref_mem();
		repeat (4) @(posedge CAP_CLK);
		#1 rst_n = 1'b1;

		// ID answer
		got.delete();
		send_byte(8'h02);
		wait_busy(1'b1, 20, "ID report start");
		wait_busy(1'b0, 1000, "ID report end");
		assert (got.size() == 4) else value_error($sformatf("ID gave %0d bytes", got.size()));
		assert ({got[0], got[1], got[2], got[3]} == "1ALS")
			else value_error($sformatf("ID is %02h %02h %02h %02h",
				got[0], got[1], got[2], got[3]));

		set_divider(24'd1, 0);     // full rate
		run_capture("mask zero, full rate");
		set_divider(24'd7, 3);     // every fourth clock
		run_capture("mask zero, divider 7");

		send_cmd5(8'hC0, 8'h81, 8'h00, 8'h00, 8'h00);
		m_mask = 8'h81;
		send_cmd5(8'hC1, 8'h80, 8'h00, 8'h00, 8'h00);
		m_sens = 8'h80;
		send_cmd5(8'h81, 8'h00, 8'h00, 8'h10, 8'h00);
		m_post = 16'h0010 << 2;    // params 3:2 times four
		run_capture("trigger");

		// code 5 is not in the table
		send_cmd5(8'h80, 8'h05, 8'h00, 8'h00, 8'h00);
		got.delete();
		send_byte(8'h01);
		repeat (64) begin
			@(posedge CAP_CLK);
			#1;
			assert (busy == 1'b0) else value_error("busy after arm with unknown divider");
		end
		assert (got.size() == 0) else value_error("bytes sent after arm with unknown divider");

		set_divider(24'd1, 0);
		send_cmd5(8'hC2, 8'h01, 8'h02, 8'hC0, 8'hFF);   // params look like commands
		send_cmd5(8'h82, 8'h81, 8'h80, 8'h00, 8'h02);
		send_byte(8'h04);
		send_byte(8'h00);
		run_capture("after ignored commands");

		$display("Verification passed");
		$finish;
	end
endmodule
